// ==== hw/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data path width
`define EXEC_XLEN 64

// link value increment for jal and jalr
`define EXEC_PC_STEP 4

// one iteration per operand bit
`define EXEC_MD_ITER `EXEC_XLEN

`define EXEC_REG_BITS 5

`endif

// ==== hw/exec_pkg.sv ====
`include "exec_params.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;

    typedef enum logic [5:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        ADDI,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        SLTI,
        SLTIU,
        LUI,
        AUIPC,
        JAL,
        JALR,
        ADDW,
        SUBW,
        MUL,
        DIV,
        DIVU,
        REM,
        REMU,
        NOP
    } exec_op_t;

    typedef enum logic [1:0] {
        IDLE,
        MUL_BUSY,
        DIV_BUSY
    } ctrl_state_t;

endpackage

// ==== hw/operand_select.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module operand_select (
    input  exec_pkg::exec_op_t op,
    input  exec_pkg::word_t    pc,
    input  exec_pkg::word_t    srca,
    input  exec_pkg::word_t    srcb,
    input  exec_pkg::word_t    immediate,
    output exec_pkg::word_t    alu_a,
    output exec_pkg::word_t    alu_b
);

    exec_pkg::word_t abs_a;
    exec_pkg::word_t abs_b;

    // two's complement magnitude for signed divide
    assign abs_a = srca[`EXEC_XLEN-1] ? (~srca + 1'b1) : srca;
    assign abs_b = srcb[`EXEC_XLEN-1] ? (~srcb + 1'b1) : srcb;

    always_comb begin
        alu_a = '0;
        alu_b = '0;
        unique case (op)
            exec_pkg::ADD, exec_pkg::SUB, exec_pkg::AND, exec_pkg::OR,
            exec_pkg::XOR, exec_pkg::SLL, exec_pkg::SRL, exec_pkg::SRA,
            exec_pkg::SLT, exec_pkg::SLTU, exec_pkg::ADDW, exec_pkg::SUBW,
            exec_pkg::MUL, exec_pkg::DIVU, exec_pkg::REMU: begin
                alu_a = srca;
                alu_b = srcb;
            end
            exec_pkg::ADDI, exec_pkg::XORI, exec_pkg::ORI, exec_pkg::ANDI,
            exec_pkg::SLLI, exec_pkg::SRLI, exec_pkg::SRAI, exec_pkg::SLTI,
            exec_pkg::SLTIU: begin
                alu_a = srca;
                alu_b = immediate;
            end
            exec_pkg::LUI: begin
                alu_a = immediate;
                alu_b = '0;
            end
            exec_pkg::AUIPC: begin
                alu_a = pc;
                alu_b = immediate;
            end
            // link address
            exec_pkg::JAL, exec_pkg::JALR: begin
                alu_a = pc;
                alu_b = exec_pkg::word_t'(`EXEC_PC_STEP);
            end
            exec_pkg::DIV, exec_pkg::REM: begin
                alu_a = abs_a;
                alu_b = abs_b;
            end
            default: begin
                alu_a = '0;
                alu_b = '0;
            end
        endcase
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module alu (
    input  exec_pkg::exec_op_t op,
    input  exec_pkg::word_t    a,
    input  exec_pkg::word_t    b,
    output exec_pkg::word_t    y
);

    localparam int SHAMT_BITS = $clog2(`EXEC_XLEN);

    logic [SHAMT_BITS-1:0] shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;

    // shift amount from the low bits only
    assign shamt       = b[SHAMT_BITS-1:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        y = '0;
        unique case (op)
            exec_pkg::ADD, exec_pkg::ADDI, exec_pkg::LUI, exec_pkg::AUIPC,
            exec_pkg::JAL, exec_pkg::JALR, exec_pkg::ADDW: begin
                y = a + b;
            end
            // word forms narrowed later
            exec_pkg::SUB, exec_pkg::SUBW: begin
                y = a - b;
            end
            exec_pkg::AND, exec_pkg::ANDI: begin
                y = a & b;
            end
            exec_pkg::OR, exec_pkg::ORI: begin
                y = a | b;
            end
            exec_pkg::XOR, exec_pkg::XORI: begin
                y = a ^ b;
            end
            exec_pkg::SLL, exec_pkg::SLLI: begin
                y = a << shamt;
            end
            exec_pkg::SRL, exec_pkg::SRLI: begin
                y = a >> shamt;
            end
            exec_pkg::SRA, exec_pkg::SRAI: begin
                y = $signed(a) >>> shamt;
            end
            exec_pkg::SLT, exec_pkg::SLTI: begin
                y = exec_pkg::word_t'(lt_signed);
            end
            exec_pkg::SLTU, exec_pkg::SLTIU: begin
                y = exec_pkg::word_t'(lt_unsigned);
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// ==== hw/multiplier.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module multiplier (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  exec_pkg::word_t a,
    input  exec_pkg::word_t b,
    output logic            done,
    output exec_pkg::word_t product
);

    localparam int CNT_BITS = $clog2(`EXEC_MD_ITER + 1);

    logic                busy;
    logic [CNT_BITS-1:0] cnt;
    exec_pkg::word_t     acc;
    exec_pkg::word_t     mcand;
    exec_pkg::word_t     mplier;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
            acc  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
                acc  <= '0;
            end else if (busy) begin
                if (mplier[0]) begin
                    acc <= acc + mcand;
                end
                cnt <= cnt + 1'b1;
                // last bit consumed
                if (cnt == CNT_BITS'(`EXEC_MD_ITER - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // operand shifters
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
        end else if (busy) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;

endmodule

// ==== hw/divider.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module divider (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  exec_pkg::word_t a,
    input  exec_pkg::word_t b,
    output logic            done,
    output exec_pkg::word_t quotient,
    output exec_pkg::word_t remainder
);

    localparam int CNT_BITS = $clog2(`EXEC_MD_ITER + 1);

    logic                 busy;
    logic [CNT_BITS-1:0]  cnt;
    exec_pkg::word_t      quot_q;
    exec_pkg::word_t      rem_q;
    exec_pkg::word_t      divisor;
    logic [`EXEC_XLEN:0]  shifted;
    logic [`EXEC_XLEN:0]  diff;

    // trial subtraction with the borrow in the msb of diff
    assign shifted = {rem_q, quot_q[`EXEC_XLEN-1]};
    assign diff    = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done   <= 1'b0;
            quot_q <= '0;
            rem_q  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy   <= 1'b1;
                cnt    <= '0;
                quot_q <= a;
                rem_q  <= '0;
            end else if (busy) begin
                if (!diff[`EXEC_XLEN]) begin
                    rem_q  <= diff[`EXEC_XLEN-1:0];
                    quot_q <= {quot_q[`EXEC_XLEN-2:0], 1'b1};
                end else begin
                    // restore
                    rem_q  <= shifted[`EXEC_XLEN-1:0];
                    quot_q <= {quot_q[`EXEC_XLEN-2:0], 1'b0};
                end
                cnt <= cnt + 1'b1;
                if (cnt == CNT_BITS'(`EXEC_MD_ITER - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            divisor <= b;
        end
    end

    assign quotient  = quot_q;
    assign remainder = rem_q;

endmodule

// ==== hw/exec_control.sv ====
`timescale 1ns/100ps

module exec_control (
    input  logic               clk,
    input  logic               reset,
    input  exec_pkg::exec_op_t op,
    input  logic               is_bubble_in,
    input  logic               mul_done,
    input  logic               div_done,
    output logic               mul_start,
    output logic               div_start,
    output logic               is_waiting,
    output logic               is_bubble
);

    exec_pkg::ctrl_state_t state;
    exec_pkg::ctrl_state_t state_next;
    logic                  is_mul;
    logic                  is_div;
    logic                  md_active;

    assign is_mul = !is_bubble_in && (op == exec_pkg::MUL);
    assign is_div = !is_bubble_in && (op == exec_pkg::DIV || op == exec_pkg::DIVU ||
                                      op == exec_pkg::REM || op == exec_pkg::REMU);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= exec_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        mul_start  = 1'b0;
        div_start  = 1'b0;
        is_waiting = 1'b0;
        unique case (state)
            exec_pkg::IDLE: begin
                if (is_mul) begin
                    mul_start  = 1'b1;
                    is_waiting = 1'b1;
                    state_next = exec_pkg::MUL_BUSY;
                end else if (is_div) begin
                    div_start  = 1'b1;
                    is_waiting = 1'b1;
                    state_next = exec_pkg::DIV_BUSY;
                end
            end
            // release the stall in the done cycle
            exec_pkg::MUL_BUSY: begin
                is_waiting = !mul_done;
                if (mul_done) begin
                    state_next = exec_pkg::IDLE;
                end
            end
            exec_pkg::DIV_BUSY: begin
                is_waiting = !div_done;
                if (div_done) begin
                    state_next = exec_pkg::IDLE;
                end
            end
            default: begin
                state_next = exec_pkg::IDLE;
            end
        endcase
    end

    assign md_active = (state != exec_pkg::IDLE) || is_mul || is_div;
    assign is_bubble = md_active ? is_waiting : is_bubble_in;

endmodule

// ==== hw/result_select.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module result_select (
    input  exec_pkg::exec_op_t op,
    input  exec_pkg::word_t    srca,
    input  exec_pkg::word_t    srcb,
    input  exec_pkg::word_t    alu_y,
    input  exec_pkg::word_t    product,
    input  exec_pkg::word_t    quotient,
    input  exec_pkg::word_t    remainder,
    output exec_pkg::word_t    result
);

    logic            div_by_zero;
    logic            sign_a;
    logic            sign_b;
    exec_pkg::word_t neg_quot;
    exec_pkg::word_t neg_rem;

    assign div_by_zero = (srcb == '0);
    assign sign_a      = srca[`EXEC_XLEN-1];
    assign sign_b      = srcb[`EXEC_XLEN-1];
    assign neg_quot    = ~quotient + 1'b1;
    assign neg_rem     = ~remainder + 1'b1;

    always_comb begin
        result = alu_y;
        unique case (op)
            exec_pkg::ADDW, exec_pkg::SUBW: begin
                result = {{(`EXEC_XLEN-32){alu_y[31]}}, alu_y[31:0]};
            end
            exec_pkg::MUL: begin
                result = product;
            end
            // quotient sign follows the operand signs
            exec_pkg::DIV: begin
                if (div_by_zero) begin
                    result = '1;
                end else begin
                    result = (sign_a ^ sign_b) ? neg_quot : quotient;
                end
            end
            exec_pkg::DIVU: begin
                result = div_by_zero ? '1 : quotient;
            end
            // remainder takes the dividend sign
            exec_pkg::REM: begin
                if (div_by_zero) begin
                    result = srca;
                end else begin
                    result = sign_a ? neg_rem : remainder;
                end
            end
            exec_pkg::REMU: begin
                result = div_by_zero ? srca : remainder;
            end
            default: begin
                result = alu_y;
            end
        endcase
    end

endmodule

// ==== hw/execute.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module execute (
    input  logic                      clk,
    input  logic                      reset,
    input  exec_pkg::exec_op_t        op,
    input  logic                      is_bubble_in,
    input  exec_pkg::word_t           pc,
    input  exec_pkg::word_t           srca,
    input  exec_pkg::word_t           srcb,
    input  exec_pkg::word_t           immediate,
    input  logic [`EXEC_REG_BITS-1:0] dst,
    output exec_pkg::word_t           result,
    output exec_pkg::word_t           out_pc,
    output exec_pkg::exec_op_t        out_op,
    output logic [`EXEC_REG_BITS-1:0] out_dst,
    output logic                      is_bubble,
    output logic                      is_waiting
);

    exec_pkg::word_t alu_a;
    exec_pkg::word_t alu_b;
    exec_pkg::word_t alu_y;
    exec_pkg::word_t product;
    exec_pkg::word_t quotient;
    exec_pkg::word_t remainder;
    logic            mul_start;
    logic            mul_done;
    logic            div_start;
    logic            div_done;

    operand_select operand_select_inst (
        .op        (op),
        .pc        (pc),
        .srca      (srca),
        .srcb      (srcb),
        .immediate (immediate),
        .alu_a     (alu_a),
        .alu_b     (alu_b)
    );

    alu alu_inst (
        .op (op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    // both units share the selected operands
    multiplier multiplier_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .a       (alu_a),
        .b       (alu_b),
        .done    (mul_done),
        .product (product)
    );

    divider divider_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .a         (alu_a),
        .b         (alu_b),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    exec_control exec_control_inst (
        .clk          (clk),
        .reset        (reset),
        .op           (op),
        .is_bubble_in (is_bubble_in),
        .mul_done     (mul_done),
        .div_done     (div_done),
        .mul_start    (mul_start),
        .div_start    (div_start),
        .is_waiting   (is_waiting),
        .is_bubble    (is_bubble)
    );

    result_select result_select_inst (
        .op        (op),
        .srca      (srca),
        .srcb      (srcb),
        .alu_y     (alu_y),
        .product   (product),
        .quotient  (quotient),
        .remainder (remainder),
        .result    (result)
    );

    assign out_pc  = pc;
    assign out_op  = op;
    assign out_dst = dst;

endmodule

// ==== test/execute_chk.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module execute_chk (
    input logic                      clk,
    input logic                      reset,
    input exec_pkg::exec_op_t        op,
    input logic                      is_bubble_in,
    input exec_pkg::word_t           pc,
    input exec_pkg::word_t           srca,
    input exec_pkg::word_t           srcb,
    input exec_pkg::word_t           immediate,
    input logic [`EXEC_REG_BITS-1:0] dst,
    input exec_pkg::word_t           result,
    input exec_pkg::word_t           out_pc,
    input exec_pkg::exec_op_t        out_op,
    input logic [`EXEC_REG_BITS-1:0] out_dst,
    input logic                      is_bubble,
    input logic                      is_waiting,
    input logic                      mul_start,
    input logic                      div_start,
    input exec_pkg::ctrl_state_t     state
);

    localparam exec_pkg::word_t MOST_NEG = {1'b1, {(`EXEC_XLEN-1){1'b0}}};

    int              fail_count = 0;
    int              wait_cycles;
    logic            md_op;
    logic            alu_op;
    exec_pkg::word_t rhs;
    exec_pkg::word_t sum;
    exec_pkg::word_t diff;
    exec_pkg::word_t expected;

    assign md_op  = op inside {exec_pkg::MUL, exec_pkg::DIV, exec_pkg::DIVU,
                               exec_pkg::REM, exec_pkg::REMU};
    assign alu_op = !md_op && (op != exec_pkg::NOP);

    // reference values from the ISA rules
    always_comb begin
        rhs  = (op inside {exec_pkg::ADDI, exec_pkg::XORI, exec_pkg::ORI, exec_pkg::ANDI,
                           exec_pkg::SLLI, exec_pkg::SRLI, exec_pkg::SRAI, exec_pkg::SLTI,
                           exec_pkg::SLTIU}) ? immediate : srcb;
        sum  = srca + rhs;
        diff = srca - rhs;
        case (op)
            exec_pkg::ADD, exec_pkg::ADDI: expected = sum;
            exec_pkg::SUB: expected = diff;
            exec_pkg::AND, exec_pkg::ANDI: expected = srca & rhs;
            exec_pkg::OR, exec_pkg::ORI: expected = srca | rhs;
            exec_pkg::XOR, exec_pkg::XORI: expected = srca ^ rhs;
            exec_pkg::SLL, exec_pkg::SLLI: expected = srca << rhs[5:0];
            exec_pkg::SRL, exec_pkg::SRLI: expected = srca >> rhs[5:0];
            exec_pkg::SRA, exec_pkg::SRAI: expected = $signed(srca) >>> rhs[5:0];
            exec_pkg::SLT, exec_pkg::SLTI: expected = exec_pkg::word_t'($signed(srca) < $signed(rhs));
            exec_pkg::SLTU, exec_pkg::SLTIU: expected = exec_pkg::word_t'(srca < rhs);
            exec_pkg::LUI: expected = immediate;
            exec_pkg::AUIPC: expected = pc + immediate;
            exec_pkg::JAL, exec_pkg::JALR: expected = pc + `EXEC_PC_STEP;
            exec_pkg::ADDW: expected = exec_pkg::word_t'($signed(sum[31:0]));
            exec_pkg::SUBW: expected = exec_pkg::word_t'($signed(diff[31:0]));
            exec_pkg::MUL: expected = srca * srcb;
            exec_pkg::DIVU: expected = (srcb == '0) ? '1 : srca / srcb;
            exec_pkg::REMU: expected = (srcb == '0) ? srca : srca % srcb;
            exec_pkg::DIV: begin
                if (srcb == '0) expected = '1;
                else if (srca == MOST_NEG && srcb == '1) expected = MOST_NEG;
                else expected = $signed(srca) / $signed(srcb);
            end
            exec_pkg::REM: begin
                if (srcb == '0) expected = srca;
                else if (srca == MOST_NEG && srcb == '1) expected = '0;
                else expected = $signed(srca) % $signed(srcb);
            end
            default: expected = '0;
        endcase
    end

    // consecutive stalled cycles
    always_ff @(posedge clk) begin
        if (reset || !is_waiting) begin
            wait_cycles <= 0;
        end else begin
            wait_cycles <= wait_cycles + 1;
        end
    end

    reset_idle: assert property (@(posedge clk) reset |=> (state == exec_pkg::IDLE && !is_waiting))
        else begin
            fail_count++;
            $error("controller not idle or still stalling right after reset");
        end

    alu_value: assert property (@(posedge clk) disable iff (reset)
        (!is_bubble_in && alu_op) |-> (result == expected))
        else begin
            fail_count++;
            $error("FAILED alu %s expected %h actual %h", op.name(), expected, result);
        end

    alu_no_bubble: assert property (@(posedge clk) disable iff (reset)
        (!is_bubble_in && alu_op) |-> !is_bubble)
        else begin
            fail_count++;
            $error("is_bubble is high for an ALU op that is not a bubble");
        end

    fields_through: assert property (@(posedge clk) disable iff (reset)
        (out_pc == pc) && (out_op == op) && (out_dst == dst))
        else begin
            fail_count++;
            $error("out_pc, out_op or out_dst does not follow its input");
        end

    // result is sampled in the done cycle
    muldiv_value: assert property (@(posedge clk) disable iff (reset)
        ($fell(is_waiting) && md_op) |-> (result == expected))
        else begin
            fail_count++;
            $error("FAILED muldiv %s expected %h actual %h", op.name(), expected, result);
        end

    // stall starts in the first cycle of a multiply or divide
    stall_bubble: assert property (@(posedge clk) disable iff (reset)
        (!is_bubble_in && md_op) |->
        ((is_bubble == is_waiting) && (is_waiting || state != exec_pkg::IDLE)))
        else begin
            fail_count++;
            $error("muldiv op not stalled or is_bubble differs from is_waiting");
        end

    stall_length: assert property (@(posedge clk) disable iff (reset)
        is_waiting |-> (wait_cycles <= `EXEC_MD_ITER))
        else begin
            fail_count++;
            $error("is_waiting stayed high longer than the unit latency");
        end

    bubble_quiet: assert property (@(posedge clk) disable iff (reset)
        (is_bubble_in && state == exec_pkg::IDLE) |->
        (is_bubble && !is_waiting && !mul_start && !div_start))
        else begin
            fail_count++;
            $error("a bubble raised a stall, a start pulse or cleared is_bubble");
        end

endmodule

bind execute execute_chk execute_chk_inst (
    .*,
    .state (exec_control_inst.state)
);

// ==== test/execute_tb.sv ====
`timescale 1ns/100ps
`include "exec_params.svh"

module execute_tb;

    localparam logic [15:0] LFSR_SEED  = 16'd11;
    localparam int          WAIT_LIMIT = 2 * `EXEC_MD_ITER;
    localparam int          ALU_ROUNDS = 6;

    logic                      clk;
    logic                      reset;
    exec_pkg::exec_op_t        op;
    logic                      is_bubble_in;
    exec_pkg::word_t           pc;
    exec_pkg::word_t           srca;
    exec_pkg::word_t           srcb;
    exec_pkg::word_t           immediate;
    logic [`EXEC_REG_BITS-1:0] dst;
    exec_pkg::word_t           result;
    exec_pkg::word_t           out_pc;
    exec_pkg::exec_op_t        out_op;
    logic [`EXEC_REG_BITS-1:0] out_dst;
    logic                      is_bubble;
    logic                      is_waiting;

    logic [15:0]     lfsr;
    exec_pkg::word_t a_val;
    exec_pkg::word_t b_val;
    int              tests_run;
    int              tests_failed;
    int              timeouts;
    int              errors_before;

    execute execute_inst (.*);

    always #5 clk = ~clk;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output exec_pkg::word_t w);
        for (int i = 0; i < `EXEC_XLEN; i++) begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    // mixes in zero, all ones and the most negative value
    task automatic pick_operand(output exec_pkg::word_t w);
        exec_pkg::word_t raw;
        random_word(raw);
        case (raw[2:0])
            3'd0: w = '0;
            3'd1: w = '1;
            3'd2: w = {1'b1, {(`EXEC_XLEN-1){1'b0}}};
            default: w = raw;
        endcase
    endtask

    task automatic drive(input exec_pkg::exec_op_t o, input logic bubble,
                         input exec_pkg::word_t a, input exec_pkg::word_t b);
        exec_pkg::word_t imm;
        exec_pkg::word_t p;
        random_word(imm);
        random_word(p);
        @(negedge clk);
        op           = o;
        is_bubble_in = bubble;
        srca         = a;
        srcb         = b;
        immediate    = imm;
        pc           = p;
        dst          = p[`EXEC_REG_BITS-1:0];
    endtask

    task automatic wait_release(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (is_waiting && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (is_waiting) begin
            $display("timeout: %s still stalled after %0d cycles", name, cycles);
            timeouts++;
        end
    endtask

    function automatic int error_total();
        return execute_inst.execute_chk_inst.fail_count + timeouts;
    endfunction

    task automatic start_test();
        errors_before = error_total();
    endtask

    // one more edge for the last op, then idle the upstream stage
    task automatic end_test(input string name);
        int errs;
        @(negedge clk);
        op           = exec_pkg::NOP;
        is_bubble_in = 1'b1;
        errs = error_total() - errors_before;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-9s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        op            = exec_pkg::NOP;
        is_bubble_in  = 1'b1;
        pc            = '0;
        srca          = '0;
        srcb          = '0;
        immediate     = '0;
        dst           = '0;
        lfsr          = LFSR_SEED;
        tests_run     = 0;
        tests_failed  = 0;
        timeouts      = 0;
        errors_before = 0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        end_test("reset");

        start_test();
        for (int r = 0; r < ALU_ROUNDS; r++) begin
            for (int k = int'(exec_pkg::ADD); k <= int'(exec_pkg::SUBW); k++) begin
                pick_operand(a_val);
                pick_operand(b_val);
                drive(exec_pkg::exec_op_t'(k), 1'b0, a_val, b_val);
            end
        end
        end_test("alu");

        start_test();
        for (int r = 0; r < 12; r++) begin
            pick_operand(a_val);
            pick_operand(b_val);
            drive(exec_pkg::MUL, 1'b0, a_val, b_val);
            wait_release("multiply");
        end
        end_test("multiply");

        start_test();
        for (int r = 0; r < 16; r++) begin
            pick_operand(a_val);
            pick_operand(b_val);
            // directed corners first
            if (r == 0) begin
                b_val = '0;
            end else if (r == 1) begin
                a_val = {1'b1, {(`EXEC_XLEN-1){1'b0}}};
                b_val = '1;
            end else if (r == 2) begin
                a_val = exec_pkg::word_t'(-7);
                b_val = exec_pkg::word_t'(2);
            end
            for (int k = int'(exec_pkg::DIV); k <= int'(exec_pkg::REMU); k++) begin
                drive(exec_pkg::exec_op_t'(k), 1'b0, a_val, b_val);
                wait_release("divide");
            end
        end
        end_test("divide");

        // back to back restarts of both units
        start_test();
        for (int r = 0; r < 4; r++) begin
            pick_operand(a_val);
            pick_operand(b_val);
            drive(exec_pkg::MUL, 1'b0, a_val, b_val);
            wait_release("stall mul");
            drive(exec_pkg::REM, 1'b0, b_val, a_val);
            wait_release("stall rem");
        end
        end_test("stall");

        start_test();
        for (int r = 0; r < 40; r++) begin
            random_word(a_val);
            drive(exec_pkg::exec_op_t'(int'(a_val[5:0]) % 31), 1'b1, a_val, b_val);
        end
        end_test("bubble");

        $display("tests run %0d, tests failed %0d, errors %0d, timeouts %0d",
                 tests_run, tests_failed, error_total(), timeouts);
        if (tests_failed == 0 && error_total() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/exec_pkg.sv
hw/operand_select.sv
hw/alu.sv
hw/multiplier.sv
hw/divider.sv
hw/exec_control.sv
hw/result_select.sv
hw/execute.sv
test/execute_chk.sv
test/execute_tb.sv

// ==== Makefile ====
TOP = execute_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
